// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_size_t;

    // funct3 of the ALU groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // R-type and I-type view
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } ri_fmt_t;

    // S-type view, also holds the upper immediate of U-type
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } su_fmt_t;

    typedef union packed {
        ri_fmt_t ri;
        su_fmt_t su;
    } instr_u;

    // All zero is a bubble
    typedef struct packed {
        alu_op_t   alu_op;
        logic      b_sel_imm;
        logic      a_sel_zero;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      reg_write;
    } ctrl_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== source/ex_mem_if.sv ====
`timescale 1ns/1ns

interface ex_mem_if
    import rv_pkg::*;
();

    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    mem_size_t mem_size;
    reg_addr_t rd;
    // ALU result or data address
    word_t     result;
    // Forwarded rs2 for stores
    word_t     store_data;

    modport exec (
        output reg_write, mem_read, mem_write, mem_size, rd, result, store_data
    );

    modport mem (
        input reg_write, mem_read, mem_write, mem_size, rd, result, store_data
    );

endinterface

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,
    input  logic   i_hold,
    input  logic   i_data_busy,
    input  logic   i_instr_resp,
    input  word_t  i_instr_rdata,
    output logic   o_instr_read,
    output word_t  o_instr_addr,
    output logic   o_freeze,
    output instr_u o_instr
);

    word_t pc;
    logic  instr_done;
    word_t instr_buf;

    assign o_instr_addr = pc;
    // No new request once this PC has been fetched during a data-side freeze
    assign o_instr_read = !i_hold && !instr_done;
    assign o_freeze     = (o_instr_read && !i_instr_resp) || i_data_busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc         <= '0;
            instr_done <= 1'b0;
            o_instr    <= NOP_INSTR;
        end else if (!o_freeze) begin
            instr_done <= 1'b0;
            if (!i_hold) begin
                pc      <= pc + 'd4;
                o_instr <= instr_done ? instr_buf : i_instr_rdata;
            end
        end else if (o_instr_read && i_instr_resp) begin
            // Fetched while the data bus still waits
            instr_done <= 1'b1;
        end
    end

    // Keeps the fetched word once the transfer is done
    always_ff @(posedge clk) begin
        if (!instr_done)
            instr_buf <= i_instr_rdata;
    end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_freeze,
    input  instr_u    i_instr,
    input  word_t     i_rs1_data,
    input  word_t     i_rs2_data,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output logic      o_hold,
    output ctrl_t     o_ctrl,
    output reg_addr_t o_rd,
    output reg_addr_t o_rs1_idx,
    output reg_addr_t o_rs2_idx,
    output word_t     o_op_a,
    output word_t     o_op_b,
    output word_t     o_imm
);

    opcode_t   opcode;
    ctrl_t     ctrl_d;
    word_t     imm_d;
    reg_addr_t rs1_d;
    reg_addr_t rs2_d;
    logic      load_use;

    function automatic alu_op_t alu_decode(logic [2:0] funct3, logic alt);
        alu_op_t op;
        case (funct3)
            F3_ADD_SUB: op = alt ? alu_sub : alu_add;
            F3_SLL:     op = alu_sll;
            F3_SLT:     op = alu_slt;
            F3_SLTU:    op = alu_sltu;
            F3_XOR:     op = alu_xor;
            F3_SRL_SRA: op = alt ? alu_sra : alu_srl;
            F3_OR:      op = alu_or;
            F3_AND:     op = alu_and;
            default:    op = alu_add;
        endcase
        return op;
    endfunction

    assign opcode = opcode_t'(i_instr.ri.opcode);

    // Unused sources stay at x0 so they never match a hazard
    always_comb begin
        ctrl_d = '0;
        imm_d  = '0;
        rs1_d  = '0;
        rs2_d  = '0;
        case (opcode)
            op_lui: begin
                ctrl_d.a_sel_zero = 1'b1;
                ctrl_d.b_sel_imm  = 1'b1;
                ctrl_d.reg_write  = 1'b1;
                imm_d = {i_instr.su.imm_hi, i_instr.su.rs2, i_instr.su.rs1,
                         i_instr.su.funct3, 12'b0};
            end
            op_imm: begin
                // Only the shifts read bit 30 as a function bit
                ctrl_d.alu_op    = alu_decode(i_instr.ri.funct3,
                    i_instr.ri.funct3 == F3_SRL_SRA && i_instr.ri.funct7 == F7_ALT);
                ctrl_d.b_sel_imm = 1'b1;
                ctrl_d.reg_write = 1'b1;
                imm_d = {{20{i_instr.ri.funct7[6]}}, i_instr.ri.funct7, i_instr.ri.rs2};
                rs1_d = i_instr.ri.rs1;
            end
            op_reg: begin
                ctrl_d.alu_op    = alu_decode(i_instr.ri.funct3,
                                              i_instr.ri.funct7 == F7_ALT);
                ctrl_d.reg_write = 1'b1;
                rs1_d = i_instr.ri.rs1;
                rs2_d = i_instr.ri.rs2;
            end
            op_load: begin
                ctrl_d.b_sel_imm = 1'b1;
                ctrl_d.mem_read  = 1'b1;
                ctrl_d.mem_size  = mem_size_t'(i_instr.ri.funct3);
                ctrl_d.reg_write = 1'b1;
                imm_d = {{20{i_instr.ri.funct7[6]}}, i_instr.ri.funct7, i_instr.ri.rs2};
                rs1_d = i_instr.ri.rs1;
            end
            op_store: begin
                ctrl_d.b_sel_imm = 1'b1;
                ctrl_d.mem_write = 1'b1;
                ctrl_d.mem_size  = mem_size_t'(i_instr.su.funct3);
                imm_d = {{20{i_instr.su.imm_hi[6]}}, i_instr.su.imm_hi, i_instr.su.imm_lo};
                rs1_d = i_instr.su.rs1;
                rs2_d = i_instr.su.rs2;
            end
            default: ;
        endcase
    end

    assign o_rs1 = rs1_d;
    assign o_rs2 = rs2_d;

    // Load in execute feeding this instruction
    assign load_use = o_ctrl.mem_read && o_rd != '0 && (o_rd == rs1_d || o_rd == rs2_d);
    assign o_hold   = load_use;

    always_ff @(posedge clk) begin
        if (i_rst)
            o_ctrl <= '0;
        else if (!i_freeze)
            o_ctrl <= load_use ? ctrl_t'('0) : ctrl_d;
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_rd      <= i_instr.ri.rd;
            o_rs1_idx <= rs1_d;
            o_rs2_idx <= rs2_d;
            o_op_a    <= i_rs1_data;
            o_op_b    <= i_rs2_data;
            o_imm     <= imm_d;
        end
    end

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ns

module regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_we,
    input  reg_addr_t i_rd,
    input  word_t     i_wdata,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [1:(1 << REG_ADDR_W) - 1];

    // x0 reads zero, a register being written reads its new value
    function automatic word_t read_port(reg_addr_t idx);
        if (idx == '0)
            return '0;
        if (i_we && idx == i_rd)
            return i_wdata;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < (1 << REG_ADDR_W); i++)
                regs[i] <= '0;
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_freeze,
    input  ctrl_t     i_ctrl,
    input  reg_addr_t i_rd,
    input  reg_addr_t i_rs1_idx,
    input  reg_addr_t i_rs2_idx,
    input  word_t     i_op_a,
    input  word_t     i_op_b,
    input  word_t     i_imm,
    input  logic      i_wb_we,
    input  reg_addr_t i_wb_rd,
    input  word_t     i_wb_data,
    ex_mem_if.exec    em
);

    word_t fwd_a;
    word_t fwd_b;
    word_t alu_a;
    word_t alu_b;
    word_t alu_y;

    // Memory stage first, a load there never reaches here thanks to the bubble
    function automatic word_t forward(reg_addr_t idx, word_t decoded);
        if (idx != '0 && em.reg_write && !em.mem_read && em.rd == idx)
            return em.result;
        if (idx != '0 && i_wb_we && i_wb_rd == idx)
            return i_wb_data;
        return decoded;
    endfunction

    always_comb begin
        fwd_a = forward(i_rs1_idx, i_op_a);
        fwd_b = forward(i_rs2_idx, i_op_b);
    end

    assign alu_a = i_ctrl.a_sel_zero ? '0 : fwd_a;
    assign alu_b = i_ctrl.b_sel_imm ? i_imm : fwd_b;

    always_comb begin
        case (i_ctrl.alu_op)
            alu_add:  alu_y = alu_a + alu_b;
            alu_sub:  alu_y = alu_a - alu_b;
            alu_sll:  alu_y = alu_a << alu_b[4:0];
            alu_slt:  alu_y = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_y = {{(XLEN-1){1'b0}}, alu_a < alu_b};
            alu_xor:  alu_y = alu_a ^ alu_b;
            alu_srl:  alu_y = alu_a >> alu_b[4:0];
            alu_sra:  alu_y = $signed(alu_a) >>> alu_b[4:0];
            alu_or:   alu_y = alu_a | alu_b;
            alu_and:  alu_y = alu_a & alu_b;
            default:  alu_y = alu_a + alu_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            em.reg_write <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
        end else if (!i_freeze) begin
            em.reg_write <= i_ctrl.reg_write;
            em.mem_read  <= i_ctrl.mem_read;
            em.mem_write <= i_ctrl.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            em.mem_size   <= i_ctrl.mem_size;
            em.rd         <= i_rd;
            em.result     <= alu_y;
            em.store_data <= fwd_b;
        end
    end

endmodule

// ==== source/mem_access.sv ====
`timescale 1ns/1ns

module mem_access
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_freeze,
    ex_mem_if.mem      em,
    input  logic       i_data_resp,
    input  word_t      i_data_rdata,
    output logic       o_data_read,
    output logic       o_data_write,
    output logic       o_data_busy,
    output word_t      o_data_addr,
    output word_t      o_data_wdata,
    output logic [3:0] o_data_mbe,
    output logic       o_wb_we,
    output reg_addr_t  o_wb_rd,
    output word_t      o_wb_data
);

    logic       data_done;
    word_t      rdata_buf;
    logic [1:0] offset;
    logic       wb_load;
    word_t      wb_result;
    word_t      wb_rdata;
    logic [1:0] wb_offset;
    mem_size_t  wb_size;
    word_t      lane;
    word_t      load_data;

    assign offset = em.result[1:0];

    // Request drops once served, even if the pipeline is still frozen
    assign o_data_read  = em.mem_read && !data_done;
    assign o_data_write = em.mem_write && !data_done;
    assign o_data_addr  = {em.result[XLEN-1:2], 2'b00};
    assign o_data_wdata = em.store_data << {offset, 3'b000};
    assign o_data_busy  = (o_data_read || o_data_write) && !i_data_resp;

    always_comb begin
        case (em.mem_size)
            mem_b, mem_bu: o_data_mbe = 4'b0001 << offset;
            mem_h, mem_hu: o_data_mbe = 4'b0011 << offset;
            default:       o_data_mbe = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst)
            data_done <= 1'b0;
        else if (!i_freeze)
            data_done <= 1'b0;
        else if ((o_data_read || o_data_write) && i_data_resp)
            data_done <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!data_done)
            rdata_buf <= i_data_rdata;
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_we <= 1'b0;
            wb_load <= 1'b0;
        end else if (!i_freeze) begin
            o_wb_we <= em.reg_write;
            wb_load <= em.mem_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_wb_rd   <= em.rd;
            wb_result <= em.result;
            wb_rdata  <= data_done ? rdata_buf : i_data_rdata;
            wb_offset <= offset;
            wb_size   <= em.mem_size;
        end
    end

    // Addressed byte or halfword moved down to bit 0
    assign lane = wb_rdata >> {wb_offset, 3'b000};

    always_comb begin
        case (wb_size)
            mem_b:   load_data = {{24{lane[7]}}, lane[7:0]};
            mem_bu:  load_data = {24'b0, lane[7:0]};
            mem_h:   load_data = {{16{lane[15]}}, lane[15:0]};
            mem_hu:  load_data = {16'b0, lane[15:0]};
            default: load_data = wb_rdata;
        endcase
    end

    assign o_wb_data = wb_load ? load_data : wb_result;

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ns

module rv_core
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,

    // Instruction bus
    output logic       o_instr_read,
    output word_t      o_instr_addr,
    input  word_t      i_instr_rdata,
    input  logic       i_instr_resp,

    // Data bus
    output logic       o_data_read,
    output logic       o_data_write,
    output word_t      o_data_addr,
    output word_t      o_data_wdata,
    output logic [3:0] o_data_mbe,
    input  word_t      i_data_rdata,
    input  logic       i_data_resp
);

    logic      freeze;
    logic      hold;
    logic      data_busy;
    instr_u    instr;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    ctrl_t     ctrl;
    reg_addr_t rd;
    reg_addr_t rs1_idx;
    reg_addr_t rs2_idx;
    word_t     op_a;
    word_t     op_b;
    word_t     imm;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    ex_mem_if ex_mem ();

    fetch_stage fetch_inst (
        .clk,
        .i_rst,
        .i_hold        (hold),
        .i_data_busy   (data_busy),
        .i_instr_resp,
        .i_instr_rdata,
        .o_instr_read,
        .o_instr_addr,
        .o_freeze      (freeze),
        .o_instr       (instr)
    );

    decode_stage decode_inst (
        .clk,
        .i_rst,
        .i_freeze   (freeze),
        .i_instr    (instr),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_hold     (hold),
        .o_ctrl     (ctrl),
        .o_rd       (rd),
        .o_rs1_idx  (rs1_idx),
        .o_rs2_idx  (rs2_idx),
        .o_op_a     (op_a),
        .o_op_b     (op_b),
        .o_imm      (imm)
    );

    regfile regfile_inst (
        .clk,
        .i_rst,
        .i_we       (wb_we),
        .i_rd       (wb_rd),
        .i_wdata    (wb_data),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_stage execute_inst (
        .clk,
        .i_rst,
        .i_freeze  (freeze),
        .i_ctrl    (ctrl),
        .i_rd      (rd),
        .i_rs1_idx (rs1_idx),
        .i_rs2_idx (rs2_idx),
        .i_op_a    (op_a),
        .i_op_b    (op_b),
        .i_imm     (imm),
        .i_wb_we   (wb_we),
        .i_wb_rd   (wb_rd),
        .i_wb_data (wb_data),
        .em        (ex_mem.exec)
    );

    mem_access mem_inst (
        .clk,
        .i_rst,
        .i_freeze     (freeze),
        .em           (ex_mem.mem),
        .i_data_resp,
        .i_data_rdata,
        .o_data_read,
        .o_data_write,
        .o_data_busy  (data_busy),
        .o_data_addr,
        .o_data_wdata,
        .o_data_mbe,
        .o_wb_we      (wb_we),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

endmodule

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb
    import rv_pkg::*;
();

    localparam int    PROG_LEN   = 200;
    localparam int    DMEM_WORDS = 64;
    localparam int    TIMEOUT    = PROG_LEN * 16 + 100;
    localparam word_t DATA_BASE  = 32'h0001_0000;

    logic       clk;
    logic       i_rst;
    logic       o_instr_read;
    word_t      o_instr_addr;
    word_t      i_instr_rdata;
    logic       i_instr_resp;
    logic       o_data_read;
    logic       o_data_write;
    word_t      o_data_addr;
    word_t      o_data_wdata;
    logic [3:0] o_data_mbe;
    word_t      i_data_rdata;
    logic       i_data_resp;

    word_t prog [PROG_LEN];
    word_t dmem [DMEM_WORDS];
    word_t model_mem [DMEM_WORDS];
    word_t model_regs [32];

    // Expected data transfers in program order
    logic       exp_write [$];
    word_t      exp_addr [$];
    word_t      exp_wdata [$];
    logic [3:0] exp_mbe [$];

    int    errors = 0;
    int    cycles = 0;
    int    n_fetches = 0;
    int    n_transfers = 0;
    word_t next_fetch = '0;

    rv_core rv_core_inst (
        .clk,
        .i_rst,
        .o_instr_read,
        .o_instr_addr,
        .i_instr_rdata,
        .i_instr_resp,
        .o_data_read,
        .o_data_write,
        .o_data_addr,
        .o_data_wdata,
        .o_data_mbe,
        .i_data_rdata,
        .i_data_resp
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, op_lui};
    endfunction

    // RV32I integer semantics by funct3 and the alternate bit
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t load_ref(word_t w, logic [1:0] off, logic [2:0] f3);
        word_t lane;
        lane = w >> (8 * off);
        case (f3)
            3'b000:  return {{24{lane[7]}}, lane[7:0]};
            3'b001:  return {{16{lane[15]}}, lane[15:0]};
            3'b100:  return {24'b0, lane[7:0]};
            3'b101:  return {16'b0, lane[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [3:0] mbe_ref(logic [2:0] f3, logic [1:0] off);
        case (f3[1:0])
            2'd0:    return 4'b0001 << off;
            2'd1:    return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t lane_mask(logic [3:0] mbe);
        return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, logic [3:0] mbe);
        return (old & ~lane_mask(mbe)) | (data & lane_mask(mbe));
    endfunction

    function automatic word_t fetch_word(word_t addr);
        if (addr[31:2] < PROG_LEN)
            return prog[addr[31:2]];
        return NOP_INSTR;
    endfunction

    // x1 holds the data base, so it is never picked as a destination
    function automatic reg_addr_t pick_rd();
        int v;
        v = $urandom_range(7, 1);
        return (v == 1) ? 5'd0 : 5'(v);
    endfunction

    task automatic push_expected(logic wr, word_t addr, logic [3:0] mbe, word_t wdata);
        exp_write.push_back(wr);
        exp_addr.push_back(addr);
        exp_mbe.push_back(mbe);
        exp_wdata.push_back(wdata);
    endtask

    // Generates the program and runs each instruction on the model
    task automatic build_program();
        int          i;
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        logic [7:0]  off;
        word_t       rnd;
        word_t       val;
        logic [3:0]  mbe;

        prog[0] = enc_u(DATA_BASE[31:12], 5'd1);
        model_regs[1] = DATA_BASE;
        for (i = 1; i < PROG_LEN; i++) begin
            kind = $urandom_range(99, 0);
            rd   = pick_rd();
            rs1  = $urandom_range(7, 0);
            rs2  = $urandom_range(7, 0);
            f3   = $urandom_range(7, 0);
            rnd  = $urandom;
            alt  = 1'b0;
            // Closing words store x2..x7
            if (i >= PROG_LEN - 6)
                kind = 100;
            if (kind < 10) begin
                prog[i] = enc_u(rnd[31:12], rd);
                val = {rnd[31:12], 12'b0};
            end else if (kind < 35) begin
                imm = rnd[11:0];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alt = (f3 == 3'd5) && rnd[20];
                    imm = {1'b0, alt, 5'b0, rnd[4:0]};
                end
                prog[i] = enc_i(imm, rs1, f3, rd, op_imm);
                val = alu_ref(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm});
            end else if (kind < 55) begin
                if (f3 == 3'd0 || f3 == 3'd5)
                    alt = rnd[20];
                prog[i] = enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
                val = alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]);
            end else if (kind < 77) begin
                // lb, lh, lw, lbu, lhu
                f3 = $urandom_range(4, 0);
                if (f3 >= 3'd3)
                    f3 = f3 + 3'd1;
                off = rnd[7:0];
                if (f3[1:0] == 2'd1)
                    off[0] = 1'b0;
                if (f3[1:0] == 2'd2)
                    off[1:0] = 2'b00;
                prog[i] = enc_i({4'b0, off}, 5'd1, f3, rd, op_load);
                push_expected(1'b0, DATA_BASE + {off[7:2], 2'b00}, 4'b0, '0);
                val = load_ref(model_mem[off[7:2]], off[1:0], f3);
            end else begin
                f3  = $urandom_range(2, 0);
                off = rnd[7:0];
                if (kind == 100) begin
                    f3  = 3'd2;
                    rs2 = i - (PROG_LEN - 6) + 2;
                    off = 4 * (i - (PROG_LEN - 6));
                end
                if (f3 == 3'd1)
                    off[0] = 1'b0;
                if (f3 == 3'd2)
                    off[1:0] = 2'b00;
                mbe = mbe_ref(f3, off[1:0]);
                val = model_regs[rs2] << (8 * off[1:0]);
                prog[i] = enc_s({4'b0, off}, rs2, 5'd1, f3);
                model_mem[off[7:2]] = merge_bytes(model_mem[off[7:2]], val, mbe);
                push_expected(1'b1, DATA_BASE + {off[7:2], 2'b00}, mbe, val);
                rd = '0;
            end
            if (rd != '0)
                model_regs[rd] = val;
        end
    endtask

    task automatic pop_expected();
        void'(exp_write.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_mbe.pop_front());
        void'(exp_wdata.pop_front());
        n_transfers++;
    endtask

    // Fetch addresses run in order from 0, no branches in the subset
    task automatic check_fetch(input word_t addr);
        if (addr !== next_fetch) begin
            errors++;
            $display("mismatch at %0t: fetch address %h, expected %h",
                     $time, addr, next_fetch);
        end
        next_fetch = next_fetch + 32'd4;
        n_fetches++;
    endtask

    task automatic check_read(input word_t addr);
        if (exp_addr.size() == 0) begin
            errors++;
            $display("unexpected read of %h at %0t after the last expected transfer", addr, $time);
            return;
        end
        if (exp_write[0]) begin
            errors++;
            $display("mismatch at %0t: read of %h, expected a write to %h",
                     $time, addr, exp_addr[0]);
        end else if (addr !== exp_addr[0]) begin
            errors++;
            $display("mismatch at %0t: read address %h, expected %h", $time, addr, exp_addr[0]);
        end
        pop_expected();
    endtask

    // Only enabled byte lanes of the write data are compared
    task automatic check_write(input word_t addr, input logic [3:0] mbe, input word_t data);
        if (exp_addr.size() == 0) begin
            errors++;
            $display("unexpected write to %h at %0t after the last expected transfer", addr, $time);
            return;
        end
        if (!exp_write[0]) begin
            errors++;
            $display("mismatch at %0t: write to %h, expected a read of %h",
                     $time, addr, exp_addr[0]);
        end else begin
            if (addr !== exp_addr[0]) begin
                errors++;
                $display("mismatch at %0t: write address %h, expected %h",
                         $time, addr, exp_addr[0]);
            end
            if (mbe !== exp_mbe[0]) begin
                errors++;
                $display("mismatch at %0t: byte enables %b, expected %b", $time, mbe, exp_mbe[0]);
            end
            if ((data & lane_mask(mbe)) !== (exp_wdata[0] & lane_mask(exp_mbe[0]))) begin
                errors++;
                $display("mismatch at %0t: write data %h, expected %h",
                         $time, data, exp_wdata[0]);
            end
        end
        pop_expected();
    endtask

    // Instruction bus slave, 0 to 3 wait cycles
    initial begin : instr_responder
        word_t addr;
        i_instr_resp  = 1'b0;
        i_instr_rdata = '0;
        @(negedge i_rst);
        forever begin
            if (o_instr_read) begin
                addr = o_instr_addr;
                check_fetch(addr);
                repeat ($urandom_range(3, 0)) begin
                    @(posedge clk);
                    #1;
                    if (o_instr_read !== 1'b1 || o_instr_addr !== addr) begin
                        errors++;
                        $display("instruction request for %h changed before its response at %0t",
                                 addr, $time);
                    end
                end
                i_instr_rdata = fetch_word(addr);
                i_instr_resp  = 1'b1;
            end
            @(posedge clk);
            #1;
            i_instr_resp = 1'b0;
        end
    end

    // Data bus slave, 0 to 3 wait cycles
    initial begin : data_responder
        word_t      addr;
        word_t      wdata;
        logic [3:0] mbe;
        logic       is_write;
        i_data_resp  = 1'b0;
        i_data_rdata = '0;
        @(negedge i_rst);
        forever begin
            if (o_data_read || o_data_write) begin
                is_write = o_data_write;
                addr     = o_data_addr;
                mbe      = o_data_mbe;
                wdata    = o_data_wdata;
                repeat ($urandom_range(3, 0)) begin
                    @(posedge clk);
                    #1;
                    if (o_data_write !== is_write || o_data_read !== !is_write
                        || o_data_addr !== addr || o_data_mbe !== mbe
                        || (is_write && o_data_wdata !== wdata)) begin
                        errors++;
                        $display("data request at %h changed before its response at %0t",
                                 addr, $time);
                    end
                end
                if (is_write) begin
                    check_write(addr, mbe, wdata);
                    dmem[addr[7:2]] = merge_bytes(dmem[addr[7:2]], wdata, mbe);
                end else begin
                    check_read(addr);
                    i_data_rdata = dmem[addr[7:2]];
                end
                i_data_resp = 1'b1;
            end
            @(posedge clk);
            #1;
            i_data_resp = 1'b0;
        end
    end

    initial begin : watchdog
        wait (cycles >= TIMEOUT);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("errors: %0d, data transfers left: %0d", errors, exp_addr.size());
        $display("tests failed");
        $finish;
    end

    initial begin : main_sequence
        int i;
        void'($urandom(99));
        i_rst = 1'b1;
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = $urandom;
            model_mem[i] = dmem[i];
        end
        for (i = 0; i < 32; i++)
            model_regs[i] = '0;
        build_program();

        repeat (3) begin
            @(posedge clk);
            #1;
            if (o_data_read !== 1'b0 || o_data_write !== 1'b0) begin
                errors++;
                $display("data bus request active during reset at %0t", $time);
            end
        end
        i_rst = 1'b0;

        // Drain all transfers, then watch for extra ones
        while (exp_addr.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);

        $display("fetches: %0d, data transfers: %0d, errors: %0d",
                 n_fetches, n_transfers, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== list.f ====
source/rv_pkg.sv
source/ex_mem_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/regfile.sv
source/execute_stage.sv
source/mem_access.sv
source/rv_core.sv
sim/rv_core_tb.sv
